// ==== bench/exec_datapath_tb.sv ====
/*
 * Execute datapath testbench
 * Applies a table of decoded instructions with freeze insertion,
 * keeps a sequential register model and feeds the write-back checker
 */

`timescale 1ns/100ps
`default_nettype none

module exec_datapath_tb import exec_pkg::*; ();

	localparam int n_rows = 25;
	localparam int reset_cycles = 16;

	logic clk;
	logic rst;
	logic insn_valid;
	logic [reg_addr_width-1:0] rd_addr;
	logic [reg_addr_width-1:0] ra_addr;
	logic [reg_addr_width-1:0] rb_addr;
	logic use_imm;
	logic [data_width-1:0] simm;
	logic [op_width-1:0] alu_op;
	logic id_freeze;
	logic ex_freeze;
	logic wb_valid;
	logic [reg_addr_width-1:0] wb_addr;
	logic [data_width-1:0] wb_data;

	// Stimulus table columns
	string row_name [n_rows];
	logic row_valid [n_rows];
	logic [reg_addr_width-1:0] row_rd [n_rows];
	logic [reg_addr_width-1:0] row_ra [n_rows];
	logic [reg_addr_width-1:0] row_rb [n_rows];
	logic row_use_imm [n_rows];
	logic [data_width-1:0] row_simm [n_rows];
	logic [op_width-1:0] row_op [n_rows];
	int row_id_frz [n_rows];
	int row_ex_frz [n_rows];

	// Sequential register model, r0 never written
	logic [data_width-1:0] model_regs [0:(2**reg_addr_width)-1];

	int seed;
	int cycle_count;
	int cycle_limit;
	int max_freeze;

	exec_datapath exec_datapath_inst (
		.clk(clk),
		.rst(rst),
		.insn_valid(insn_valid),
		.rd_addr(rd_addr),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.use_imm(use_imm),
		.simm(simm),
		.alu_op(alu_op),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	wb_checker wb_checker_inst (
		.clk(clk),
		.rst(rst),
		.ex_freeze(ex_freeze),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Table and reference model
	////////////////////////////////////////////////////////////

	task automatic set_row(input int i, input string name, input logic valid, input int rd,
			input int ra, input int rb, input logic imm, input logic [op_width-1:0] op,
			input int id_frz, input int ex_frz);
		row_name[i] = name;
		row_valid[i] = valid;
		row_rd[i] = rd;
		row_ra[i] = ra;
		row_rb[i] = rb;
		row_use_imm[i] = imm;
		row_simm[i] = $random(seed);
		row_op[i] = op;
		row_id_frz[i] = id_frz;
		row_ex_frz[i] = ex_frz;
	endtask

	task automatic fill_table();
		// Index, name, valid, rd, ra, rb, use_imm, op, id_freeze cycles, ex_freeze cycles
		set_row(0, "reset_read", 1, 1, 7, 9, 0, op_add, 0, 0);
		set_row(1, "imm_add", 1, 2, 0, 0, 1, op_add, 0, 0);
		set_row(2, "imm_xor", 1, 3, 0, 0, 1, op_xor, 0, 0);
		set_row(3, "imm_or", 1, 4, 0, 0, 1, op_or, 0, 0);
		set_row(4, "bubble", 0, 0, 0, 0, 0, op_add, 0, 0);
		set_row(5, "reg_sub", 1, 5, 2, 3, 0, op_sub, 0, 0);
		set_row(6, "reg_and", 1, 6, 4, 2, 0, op_and, 0, 0);
		set_row(7, "reg_xor", 1, 7, 2, 4, 0, op_xor, 0, 0);
		// Dependency distance 1 then 2 then 3
		set_row(8, "fwd_ex_a", 1, 8, 7, 3, 0, op_add, 0, 0);
		set_row(9, "fwd_ex_b", 1, 9, 2, 8, 0, op_sub, 0, 0);
		set_row(10, "fwd_wb", 1, 10, 8, 6, 0, op_or, 0, 0);
		set_row(11, "fwd_both", 1, 11, 10, 9, 0, op_xor, 0, 0);
		set_row(12, "two_apart", 1, 12, 9, 6, 0, op_add, 0, 0);
		set_row(13, "rewrite", 1, 12, 12, 0, 1, op_xor, 0, 0);
		set_row(14, "ex_priority", 1, 13, 12, 11, 0, op_sub, 0, 0);
		// Register 0 as destination and as source
		set_row(15, "r0_write", 1, 0, 5, 0, 1, op_add, 0, 0);
		set_row(16, "r0_read_a", 1, 14, 0, 13, 0, op_add, 0, 0);
		set_row(17, "r0_read_b", 1, 15, 5, 0, 0, op_sub, 0, 0);
		// Decode freezes behind a producer
		set_row(18, "producer", 1, 16, 15, 0, 1, op_add, 0, 0);
		set_row(19, "id_freeze_ex", 1, 17, 16, 14, 0, op_and, 3, 0);
		set_row(20, "id_freeze_rf", 1, 18, 17, 16, 0, op_xor, 2, 0);
		// Execute freezes inside a chain
		set_row(21, "chain_plain", 1, 19, 18, 17, 0, op_add, 0, 0);
		set_row(22, "ex_freeze_mid", 1, 20, 19, 18, 0, op_sub, 0, 3);
		set_row(23, "ex_id_freeze", 1, 21, 20, 19, 0, op_xor, 1, 2);
		set_row(24, "alu_default", 1, 22, 21, 20, 0, 3'd7, 0, 0);
	endtask

	// Reference ALU from the op code list, unknown codes add
	function automatic logic [data_width-1:0] alu_model(input logic [op_width-1:0] op,
			input logic [data_width-1:0] a, input logic [data_width-1:0] b);
		case (op)
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			default: return a + b;
		endcase
	endfunction

	// One accepted instruction, in program order
	task automatic record_accept(input int i);
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic [data_width-1:0] result;
		if (row_valid[i]) begin
			a = model_regs[row_ra[i]];
			b = row_use_imm[i] ? row_simm[i] : model_regs[row_rb[i]];
			result = alu_model(row_op[i], a, b);
			if (row_rd[i] != '0)
				model_regs[row_rd[i]] = result;
			wb_checker_inst.push_expected(row_name[i], row_rd[i], result);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_row(input int i, input logic id_frz, input logic ex_frz);
		insn_valid = row_valid[i];
		rd_addr = row_rd[i];
		ra_addr = row_ra[i];
		rb_addr = row_rb[i];
		use_imm = row_use_imm[i];
		simm = row_simm[i];
		alu_op = row_op[i];
		id_freeze = id_frz;
		ex_freeze = ex_frz;
	endtask

	// Execute freeze cycles, then decode freeze cycles, then acceptance
	task automatic apply_row(input int i);
		int c;
		for (c = 0; c < row_ex_frz[i]; c++) begin
			drive_row(i, 1'b0, 1'b1);
			@(posedge clk);
			#1;
		end
		for (c = 0; c < row_id_frz[i]; c++) begin
			drive_row(i, 1'b1, 1'b0);
			@(posedge clk);
			#1;
		end
		drive_row(i, 1'b0, 1'b0);
		@(posedge clk);
		record_accept(i);
		#1;
	endtask

	// Run limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, write-backs still pending", cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		insn_valid = 1'b0;
		rd_addr = '0;
		ra_addr = '0;
		rb_addr = '0;
		use_imm = 1'b0;
		simm = '0;
		alu_op = op_add;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		seed = 66;
		cycle_count = 0;
		max_freeze = 0;
		fill_table();
		for (int i = 0; i < n_rows; i++) begin
			if (row_id_frz[i] + row_ex_frz[i] > max_freeze)
				max_freeze = row_id_frz[i] + row_ex_frz[i];
		end
		cycle_limit = reset_cycles + n_rows * (1 + max_freeze) + 50;
		// Reset clears every register
		for (int r = 0; r < 2**reg_addr_width; r++)
			model_regs[r] = '0;

		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int i = 0; i < n_rows; i++)
			apply_row(i);

		// Idle decode and drain the pipeline
		insn_valid = 1'b0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		while (wb_checker_inst.pending_count() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);

		wb_checker_inst.final_report();
		if (wb_checker_inst.error_total() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/operand_muxes_assert.sv ====
/*
 * Operand register assertions
 * Bound into operand_muxes, checks the hold and save rules
 * and the source decoding of both operands
 */

`timescale 1ns/100ps
`default_nettype none

module operand_muxes_assert import exec_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic id_freeze,
	input wire logic ex_freeze,
	input wire logic [1:0] saved,
	input wire logic [data_width-1:0] rf_data_a,
	input wire logic [data_width-1:0] rf_data_b,
	input wire logic [data_width-1:0] ex_forw,
	input wire logic [data_width-1:0] wb_forw,
	input wire logic [data_width-1:0] simm,
	input wire logic [sel_width-1:0] sel_a,
	input wire logic [sel_width-1:0] sel_b,
	input wire logic [data_width-1:0] operand_a,
	input wire logic [data_width-1:0] operand_b
);

	// Execute frozen, both operands hold
	assert property (@(posedge clk) disable iff (rst)
		ex_freeze |=> $stable(operand_a) && $stable(operand_b))
		else $error("operands changed while execute was frozen");

	// Saved value survives the rest of the decode freeze
	assert property (@(posedge clk) disable iff (rst)
		saved[0] && id_freeze |=> $stable(operand_a))
		else $error("saved operand A changed during decode freeze");
	assert property (@(posedge clk) disable iff (rst)
		saved[1] && id_freeze |=> $stable(operand_b))
		else $error("saved operand B changed during decode freeze");

	// Free-running load takes the source named by the select code
	// Operand A has no immediate path
	assert property (@(posedge clk) disable iff (rst)
		!ex_freeze && !id_freeze && !saved[0] |=> operand_a == $past(
			(sel_a == sel_ex_forw) ? ex_forw :
			(sel_a == sel_wb_forw) ? wb_forw : rf_data_a))
		else $error("operand A differs from its selected source");
	assert property (@(posedge clk) disable iff (rst)
		!ex_freeze && !id_freeze && !saved[1] |=> operand_b == $past(
			(sel_b == sel_imm) ? simm :
			(sel_b == sel_ex_forw) ? ex_forw :
			(sel_b == sel_wb_forw) ? wb_forw : rf_data_b))
		else $error("operand B differs from its selected source");

endmodule

bind operand_muxes operand_muxes_assert operand_muxes_assert_inst (
	.clk(clk),
	.rst(rst),
	.id_freeze(id_freeze),
	.ex_freeze(ex_freeze),
	.saved(saved),
	.rf_data_a(rf_data_a),
	.rf_data_b(rf_data_b),
	.ex_forw(ex_forw),
	.wb_forw(wb_forw),
	.simm(simm),
	.sel_a(sel_a),
	.sel_b(sel_b),
	.operand_a(operand_a),
	.operand_b(operand_b)
);

`default_nettype wire

// ==== bench/wb_checker.sv ====
/*
 * Write-back checker
 * Compares each committed write-back with the next result queued
 * by the testbench reference model and keeps the error counts
 */

`timescale 1ns/100ps
`default_nettype none

module wb_checker import exec_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic ex_freeze,
	input wire logic wb_valid,
	input wire logic [reg_addr_width-1:0] wb_addr,
	input wire logic [data_width-1:0] wb_data
);

	// Expected write-backs in program order
	string exp_name [$];
	logic [reg_addr_width-1:0] exp_addr [$];
	logic [data_width-1:0] exp_data [$];

	int compared = 0;
	int data_errors = 0;
	int addr_errors = 0;
	int unexpected = 0;

	task automatic push_expected(input string name, input logic [reg_addr_width-1:0] addr,
			input logic [data_width-1:0] data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	function automatic int pending_count();
		return exp_name.size();
	endfunction

	function automatic int error_total();
		return data_errors + addr_errors + unexpected + exp_name.size();
	endfunction

	////////////////////////////////////////////////////////////
	// Compare
	////////////////////////////////////////////////////////////

	// Sampled mid-cycle, a write-back commits when ex_freeze is low
	// Repeats under ex_freeze are therefore counted once
	always @(negedge clk) begin
		string name;
		logic [reg_addr_width-1:0] addr;
		logic [data_width-1:0] data;
		if (!rst && wb_valid && !ex_freeze) begin
			if (exp_name.size() == 0) begin
				unexpected++;
				$display("Unexpected write-back to r%0d with data %h", wb_addr, wb_data);
			end else begin
				name = exp_name.pop_front();
				addr = exp_addr.pop_front();
				data = exp_data.pop_front();
				compared++;
				if (wb_addr !== addr) begin
					addr_errors++;
					$display("Error: %s wb_addr expected %0d actual %0d", name, addr, wb_addr);
				end
				if (wb_data !== data) begin
					data_errors++;
					$display("Error: %s wb_data expected %h actual %h", name, data, wb_data);
				end
			end
		end
	end

	task automatic final_report();
		if (exp_name.size() != 0)
			$display("%0d write-backs never arrived, first is %s", exp_name.size(), exp_name[0]);
		if (unexpected != 0)
			$display("%0d write-backs arrived that were not expected", unexpected);
		$display("Write-back checks: %0d compared, %0d data errors, %0d address errors, %0d missing, %0d unexpected",
			compared, data_errors, addr_errors, exp_name.size(), unexpected);
	endtask

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/exec_pkg.sv
hdl/reg_file.sv
hdl/forward_ctrl.sv
hdl/operand_muxes.sv
hdl/execute_stage.sv
hdl/exec_datapath.sv
bench/operand_muxes_assert.sv
bench/wb_checker.sv
bench/exec_datapath_tb.sv

// ==== hdl/exec_datapath.sv ====
/*
 * Execute datapath top
 * Register file, forwarding control, operand muxes and execute
 * stage, with write-back closing the loop into the register file
 */

`timescale 1ns/100ps
`default_nettype none

module exec_datapath import exec_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic insn_valid,
	input wire logic [reg_addr_width-1:0] rd_addr,
	input wire logic [reg_addr_width-1:0] ra_addr,
	input wire logic [reg_addr_width-1:0] rb_addr,
	input wire logic use_imm,
	input wire logic [data_width-1:0] simm,
	input wire logic [op_width-1:0] alu_op,
	input wire logic id_freeze,
	input wire logic ex_freeze,
	output logic wb_valid,
	output logic [reg_addr_width-1:0] wb_addr,
	output logic [data_width-1:0] wb_data
);

	// Register file read data
	logic [data_width-1:0] rf_data_a;
	logic [data_width-1:0] rf_data_b;
	// Operand selects
	logic [sel_width-1:0] sel_a;
	logic [sel_width-1:0] sel_b;
	// Registered operands into execute
	logic [data_width-1:0] operand_a;
	logic [data_width-1:0] operand_b;
	// Execute stage state seen by forwarding
	logic ex_valid;
	logic [reg_addr_width-1:0] ex_rd;
	logic [data_width-1:0] ex_forw;
	// Register file write, once at the end of the valid cycle
	logic rf_we;

	assign rf_we = wb_valid & ~ex_freeze;

	reg_file reg_file_inst (
		.clk(clk),
		.rst(rst),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.we(rf_we),
		.wr_addr(wb_addr),
		.wr_data(wb_data),
		.rf_data_a(rf_data_a),
		.rf_data_b(rf_data_b)
	);

	forward_ctrl forward_ctrl_inst (
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.use_imm(use_imm),
		.ex_valid(ex_valid),
		.ex_rd(ex_rd),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.sel_a(sel_a),
		.sel_b(sel_b)
	);

	// wb_data doubles as the write-back forwarding source
	operand_muxes operand_muxes_inst (
		.clk(clk),
		.rst(rst),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.rf_data_a(rf_data_a),
		.rf_data_b(rf_data_b),
		.ex_forw(ex_forw),
		.wb_forw(wb_data),
		.simm(simm),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.operand_a(operand_a),
		.operand_b(operand_b)
	);

	execute_stage execute_stage_inst (
		.clk(clk),
		.rst(rst),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.insn_valid(insn_valid),
		.rd_addr(rd_addr),
		.alu_op(alu_op),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.ex_valid(ex_valid),
		.ex_rd(ex_rd),
		.ex_forw(ex_forw),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== hdl/exec_pkg.sv ====
/*
 * Execute datapath shared definitions
 * Widths, operand select codes and ALU op codes used by
 * the register file, forwarding control, muxes and execute stage
 */

`default_nettype none

package exec_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Operand and result width
	localparam int unsigned data_width = 32;
	// 32 architectural registers, r0 hard-wired to zero
	localparam int unsigned reg_addr_width = 5;
	localparam int unsigned sel_width = 2;
	localparam int unsigned op_width = 3;

	////////////////////////////////////////////////////////////
	// Operand select codes
	////////////////////////////////////////////////////////////

	localparam logic [sel_width-1:0] sel_rf = 2'd0;
	// Immediate, only meaningful for operand B
	localparam logic [sel_width-1:0] sel_imm = 2'd1;
	// Combinational result of the instruction in execute
	localparam logic [sel_width-1:0] sel_ex_forw = 2'd2;
	// Result waiting in write-back, not yet in the register file
	localparam logic [sel_width-1:0] sel_wb_forw = 2'd3;

	////////////////////////////////////////////////////////////
	// ALU op codes
	////////////////////////////////////////////////////////////

	// Unused codes fall back to add
	localparam logic [op_width-1:0] op_add = 3'd0;
	localparam logic [op_width-1:0] op_sub = 3'd1;
	localparam logic [op_width-1:0] op_and = 3'd2;
	localparam logic [op_width-1:0] op_or = 3'd3;
	localparam logic [op_width-1:0] op_xor = 3'd4;

endpackage

`default_nettype wire

// ==== hdl/execute_stage.sv ====
/*
 * Execute stage
 * Execute control register with bubble insertion, the ALU and the
 * write-back register; drives both forwarding sources
 */

`timescale 1ns/100ps
`default_nettype none

module execute_stage import exec_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic id_freeze,
	input wire logic ex_freeze,
	input wire logic insn_valid,
	input wire logic [reg_addr_width-1:0] rd_addr,
	input wire logic [op_width-1:0] alu_op,
	input wire logic [data_width-1:0] operand_a,
	input wire logic [data_width-1:0] operand_b,
	output logic ex_valid,
	output logic [reg_addr_width-1:0] ex_rd,
	output logic [data_width-1:0] ex_forw,
	output logic wb_valid,
	output logic [reg_addr_width-1:0] wb_addr,
	output logic [data_width-1:0] wb_data
);

	logic [op_width-1:0] ex_op;

	////////////////////////////////////////////////////////////
	// Execute control register
	////////////////////////////////////////////////////////////

	// Decode frozen while execute runs -> bubble goes in
	// Instruction itself is taken later when both freezes drop
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_rd <= '0;
			ex_op <= op_add;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				ex_valid <= 1'b0;
			end else begin
				ex_valid <= insn_valid;
				ex_rd <= rd_addr;
				ex_op <= alu_op;
			end
		end
	end

	// ALU, result is also the execute forwarding path
	always_comb begin
		case (ex_op)
			op_sub: ex_forw = operand_a - operand_b;
			op_and: ex_forw = operand_a & operand_b;
			op_or: ex_forw = operand_a | operand_b;
			op_xor: ex_forw = operand_a ^ operand_b;
			default: ex_forw = operand_a + operand_b;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Write-back register
	////////////////////////////////////////////////////////////

	// Holds (and wb_valid repeats) while ex_freeze is high
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_addr <= '0;
		end else if (!ex_freeze) begin
			wb_valid <= ex_valid;
			wb_addr <= ex_rd;
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (!ex_freeze)
			wb_data <= ex_forw;
	end

endmodule

`default_nettype wire

// ==== hdl/forward_ctrl.sv ====
/*
 * Forwarding control
 * Compares decode source registers with the execute and write-back
 * destinations and encodes where each operand comes from
 */

`timescale 1ns/100ps
`default_nettype none

module forward_ctrl import exec_pkg::*; (
	input wire logic [reg_addr_width-1:0] ra_addr,
	input wire logic [reg_addr_width-1:0] rb_addr,
	input wire logic use_imm,
	input wire logic ex_valid,
	input wire logic [reg_addr_width-1:0] ex_rd,
	input wire logic wb_valid,
	input wire logic [reg_addr_width-1:0] wb_addr,
	output logic [sel_width-1:0] sel_a,
	output logic [sel_width-1:0] sel_b
);

	// Hazard flags per operand and per older stage
	logic ex_hit_a;
	logic ex_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	////////////////////////////////////////////////////////////
	// Read-after-write detection
	////////////////////////////////////////////////////////////

	// Destination 0 never forwards, r0 stays zero
	always_comb begin
		ex_hit_a = ex_valid && (ex_rd != '0) && (ex_rd == ra_addr);
		ex_hit_b = ex_valid && (ex_rd != '0) && (ex_rd == rb_addr);
		wb_hit_a = wb_valid && (wb_addr != '0) && (wb_addr == ra_addr);
		wb_hit_b = wb_valid && (wb_addr != '0) && (wb_addr == rb_addr);
	end

	////////////////////////////////////////////////////////////
	// Select encoding
	////////////////////////////////////////////////////////////

	// Operand A
	// Younger producer in execute beats write-back
	always_comb begin
		if (ex_hit_a)
			sel_a = sel_ex_forw;
		else if (wb_hit_a)
			sel_a = sel_wb_forw;
		else
			sel_a = sel_rf;
	end

	// Operand B
	// Immediate overrides any register match
	always_comb begin
		if (use_imm)
			sel_b = sel_imm;
		else if (ex_hit_b)
			sel_b = sel_ex_forw;
		else if (wb_hit_b)
			sel_b = sel_wb_forw;
		else
			sel_b = sel_rf;
	end

endmodule

`default_nettype wire

// ==== hdl/operand_muxes.sv ====
/*
 * Operand multiplexers and operand registers
 * Picks each operand from register data, forwarded results or the
 * immediate, and registers it into execute under the freeze rules
 */

`timescale 1ns/100ps
`default_nettype none

module operand_muxes import exec_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic id_freeze,
	input wire logic ex_freeze,
	input wire logic [data_width-1:0] rf_data_a,
	input wire logic [data_width-1:0] rf_data_b,
	input wire logic [data_width-1:0] ex_forw,
	input wire logic [data_width-1:0] wb_forw,
	input wire logic [data_width-1:0] simm,
	input wire logic [sel_width-1:0] sel_a,
	input wire logic [sel_width-1:0] sel_b,
	output logic [data_width-1:0] operand_a,
	output logic [data_width-1:0] operand_b
);

	// Index 0 is operand A, index 1 is operand B
	logic [1:0][data_width-1:0] muxed;
	logic [1:0][data_width-1:0] operand_q;
	// Set once a value was captured while decode is frozen
	logic [1:0] saved;

	////////////////////////////////////////////////////////////
	// Source selection
	////////////////////////////////////////////////////////////

	// Operand A, three sources
	// sel_imm is never produced for A, treat it as register data
	always_comb begin
		case (sel_a)
			sel_ex_forw: muxed[0] = ex_forw;
			sel_wb_forw: muxed[0] = wb_forw;
			default: muxed[0] = rf_data_a;
		endcase
	end

	// Operand B, four sources
	always_comb begin
		case (sel_b)
			sel_imm: muxed[1] = simm;
			sel_ex_forw: muxed[1] = ex_forw;
			sel_wb_forw: muxed[1] = wb_forw;
			default: muxed[1] = rf_data_b;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////

	// ex_freeze holds everything
	// First id_freeze cycle captures the forwarded value once, because
	// the producer moves on while decode waits
	// Saved value is kept until both freezes drop, then it enters
	// execute together with its instruction
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (rst) begin
				operand_q[i] <= '0;
				saved[i] <= 1'b0;
			end else if (!ex_freeze) begin
				if (!saved[i]) begin
					operand_q[i] <= muxed[i];
					saved[i] <= id_freeze;
				end else if (!id_freeze) begin
					saved[i] <= 1'b0;
				end
			end
		end
	end

	assign operand_a = operand_q[0];
	assign operand_b = operand_q[1];

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
/*
 * Register file
 * Two combinational read ports and one synchronous write port,
 * register 0 always reads as zero
 */

`timescale 1ns/100ps
`default_nettype none

module reg_file import exec_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic [reg_addr_width-1:0] ra_addr,
	input wire logic [reg_addr_width-1:0] rb_addr,
	input wire logic we,
	input wire logic [reg_addr_width-1:0] wr_addr,
	input wire logic [data_width-1:0] wr_data,
	output logic [data_width-1:0] rf_data_a,
	output logic [data_width-1:0] rf_data_b
);

	// Storage for r1..r31 only, r0 has no flops
	logic [data_width-1:0] regs [1:(2**reg_addr_width)-1];

	// Write port
	// Reset clears every register so early reads see zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 2**reg_addr_width; i++)
				regs[i] <= '0;
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Read ports, no bypass of a same-cycle write
	// (write-back forwarding covers that case)
	always_comb begin
		rf_data_a = (ra_addr == '0) ? '0 : regs[ra_addr];
		rf_data_b = (rb_addr == '0) ? '0 : regs[rb_addr];
	end

endmodule

`default_nettype wire
